// File: include/hub75_macros.svh
// **********************************************************
// hub75 panel geometry
// banks, rows, columns, channels, bitplanes and the
// address widths derived from them
// **********************************************************

`ifndef HUB75_MACROS_SVH
`define HUB75_MACROS_SVH

`define HUB75_N_BANKS   2                    // banks shifted in parallel
`define HUB75_N_ROWS    8                    // row addresses per bank, power of two
`define HUB75_N_COLS    16                   // columns per row
`define HUB75_N_CHANS   3                    // r, g, b
`define HUB75_N_PLANES  4                    // bits per channel = bitplanes

`define HUB75_LOG_ROWS  $clog2(`HUB75_N_ROWS)   // row address width
`define HUB75_LOG_COLS  $clog2(`HUB75_N_COLS)   // column address width
`define HUB75_LOG_BANKS $clog2(`HUB75_N_BANKS)  // bank select width

`endif

// File: logic/hub75_pkg.sv
// **********************************************************
// hub75 shared types
// pixel, host write, timing config and panel pin bundles
// **********************************************************

`include "hub75_macros.svh"

package hub75_pkg;

	typedef struct packed {
		logic [`HUB75_N_PLANES-1:0] r;       // msb field
		logic [`HUB75_N_PLANES-1:0] g;
		logic [`HUB75_N_PLANES-1:0] b;
	} pixel_t;

	typedef struct packed {
		logic                        en;     // write strobe
		logic [`HUB75_LOG_BANKS-1:0] bank;
		logic [`HUB75_LOG_ROWS-1:0]  row;
		logic [`HUB75_LOG_COLS-1:0]  col;
		pixel_t                      data;
	} fb_wr_t;

	typedef struct packed {
		logic [7:0] pre_latch_len;           // blank high before le
		logic [7:0] latch_len;               // le width
		logic [7:0] post_latch_len;          // gap after le
		logic [7:0] bit_len;                 // display time of plane 0
	} hub75_cfg_t;

	typedef struct packed {
		logic [`HUB75_LOG_ROWS-1:0]                   addr;
		logic [`HUB75_N_BANKS*`HUB75_N_CHANS-1:0]     data;   // bank b chan c at b*3+c
		logic                                         clk;
		logic                                         le;
		logic                                         blank;
	} hub75_pins_t;

endpackage

// File: logic/hub75_framebuffer.sv
// **********************************************************
// hub75 frame buffer
// two pixel stores, host writes land in the back one,
// scan reads come from the front one, swap flips them
// **********************************************************

`timescale 1ns/1ps

`include "hub75_macros.svh"

module hub75_framebuffer (
	input  logic                                        clk,
	input  logic                                        rst,
	// host side
	input  hub75_pkg::fb_wr_t                           wr,
	input  logic                                        swap,     // one-cycle front/back flip
	// scan side
	input  logic [`HUB75_LOG_ROWS-1:0]                  rd_row,
	input  logic [`HUB75_LOG_COLS-1:0]                  rd_col,
	input  logic                                        rd_en,
	output hub75_pkg::pixel_t [`HUB75_N_BANKS-1:0]      rd_data   // all banks, one cycle late
);

	localparam int DEPTH = `HUB75_N_ROWS * `HUB75_N_COLS;  // pixels per bank

	logic front;                                  // buffer the panel shows

	// [buffer][bank][row,col]
	hub75_pkg::pixel_t mem [2][`HUB75_N_BANKS][DEPTH];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			front <= 1'b0;                        // buffer 0 visible after reset
		end else if (swap) begin
			front <= ~front;
		end
	end

	// host port, always the hidden half
	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[~front][wr.bank][{wr.row, wr.col}] <= wr.data;
		end
	end

	// scan port, every bank at the same row/col
	always_ff @(posedge clk) begin
		if (rd_en) begin
			for (int b = 0; b < `HUB75_N_BANKS; b++) begin
				rd_data[b] <= mem[front][b][{rd_row, rd_col}];
			end
		end
	end

	// a write racing a flip would land in an undefined half
	a_no_swap_on_write: assert property (
		@(posedge clk) disable iff (rst)
		!(swap && wr.en)
	) else $error("frame swap while a host write is pending");

endmodule

// File: logic/hub75_scan.sv
// **********************************************************
// hub75 row scan
// steps through rows 0..N-1 once per frame, one bcm
// request per row, ready again at the frame boundary
// **********************************************************

`timescale 1ns/1ps

`include "hub75_macros.svh"

module hub75_scan (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        ctrl_go,    // start one frame
	output logic                        ctrl_rdy,   // idle, between frames
	output logic                        bcm_go,
	output logic [`HUB75_LOG_ROWS-1:0]  bcm_row,
	input  logic                        bcm_rdy
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_GO,                                   // bcm_go cycle
		S_WAIT                                  // row in progress
	} state_t;

	state_t                       state;
	logic [`HUB75_LOG_ROWS-1:0]   row;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			row   <= '0;
		end else begin
			case (state)
				S_IDLE: if (ctrl_go) begin
					row   <= '0;                    // linear scan from top
					state <= S_GO;
				end
				S_GO: state <= S_WAIT;              // bcm_rdy drops next cycle
				S_WAIT: if (bcm_rdy) begin
					if (&row) begin
						state <= S_IDLE;            // last row done
					end else begin
						row   <= row + 1'b1;
						state <= S_GO;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign ctrl_rdy = (state == S_IDLE);
	assign bcm_go   = (state == S_GO);
	assign bcm_row  = row;                      // held for the whole row

	a_go_when_rdy: assert property (
		@(posedge clk) disable iff (rst)
		ctrl_go |-> ctrl_rdy
	) else $error("scan started while a frame is running");

endmodule

// File: logic/hub75_bcm.sv
// **********************************************************
// hub75 binary code modulator
// runs the planes of one row lsb first, latch sequence
// per plane, next plane shifts while this one is shown
// **********************************************************

`timescale 1ns/1ps

`include "hub75_macros.svh"

module hub75_bcm (
	input  logic                          clk,
	input  logic                          rst,
	// from scan
	input  logic                          ctrl_go,
	input  logic [`HUB75_LOG_ROWS-1:0]    ctrl_row,
	output logic                          ctrl_rdy,
	input  hub75_pkg::hub75_cfg_t         cfg,
	// shifter
	output logic                          shift_go,
	output logic [`HUB75_N_PLANES-1:0]    shift_plane,   // one-hot
	input  logic                          shift_rdy,
	// blanking
	output logic                          blank_go,
	output logic [`HUB75_N_PLANES-1:0]    blank_plane,   // one-hot
	input  logic                          blank_rdy,
	// to phy
	output logic [`HUB75_LOG_ROWS-1:0]    phy_addr,
	output logic                          phy_le
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,                                // shift of plane 0
		S_WAIT,                                 // shift done and previous plane shown
		S_PRE,
		S_LATCH,
		S_POST,
		S_FIRE,                                 // show plane, shift next
		S_DRAIN                                 // last plane on display
	} state_t;

	state_t                       state;
	logic [`HUB75_N_PLANES-1:0]   plane;        // one-hot, current plane
	logic [`HUB75_LOG_ROWS-1:0]   row_q;
	logic [`HUB75_LOG_ROWS-1:0]   addr;
	logic [7:0]                   cnt;          // shared phase timer

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			plane <= '0;
			row_q <= '0;
			addr  <= '0;
			cnt   <= '0;
		end else begin
			case (state)
				S_IDLE: if (ctrl_go) begin
					row_q <= ctrl_row;
					plane <= `HUB75_N_PLANES'(1);   // lsb plane first
					state <= S_START;
				end
				S_START: state <= S_WAIT;
				S_WAIT: if (shift_rdy && blank_rdy) begin
					cnt   <= cfg.pre_latch_len;
					state <= S_PRE;
				end
				S_PRE: if (cnt <= 8'd1) begin
					cnt   <= cfg.latch_len;
					state <= S_LATCH;
					if (plane[0])
						addr <= row_q;              // new row goes out with first latch
				end else begin
					cnt <= cnt - 1'b1;
				end
				S_LATCH: if (cnt <= 8'd1) begin
					cnt   <= cfg.post_latch_len;
					state <= S_POST;
				end else begin
					cnt <= cnt - 1'b1;
				end
				S_POST: if (cnt <= 8'd1) state <= S_FIRE;
					else cnt <= cnt - 1'b1;
				S_FIRE: if (plane[`HUB75_N_PLANES-1]) begin
					state <= S_DRAIN;               // nothing left to shift
				end else begin
					plane <= {plane[`HUB75_N_PLANES-2:0], 1'b0};
					state <= S_WAIT;
				end
				S_DRAIN: if (blank_rdy) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	assign ctrl_rdy    = (state == S_IDLE);
	assign shift_go    = (state == S_START) ||
	                     ((state == S_FIRE) && !plane[`HUB75_N_PLANES-1]);
	assign shift_plane = (state == S_FIRE) ? {plane[`HUB75_N_PLANES-2:0], 1'b0} : plane;
	assign blank_go    = (state == S_FIRE);
	assign blank_plane = plane;
	assign phy_addr    = addr;
	assign phy_le      = (state == S_LATCH);

	// latching while lit would smear the previous plane
	a_le_blanked: assert property (
		@(posedge clk) disable iff (rst)
		phy_le |-> blank_rdy
	) else $error("le raised while the panel is lit");

endmodule

// File: logic/hub75_shift.sv
// **********************************************************
// hub75 column shifter
// reads each column, picks one bitplane per channel and
// clocks it out with a two-phase panel clock
// **********************************************************

`timescale 1ns/1ps

`include "hub75_macros.svh"

module hub75_shift (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          ctrl_go,
	input  logic [`HUB75_N_PLANES-1:0]                    ctrl_plane,   // one-hot
	input  logic [`HUB75_LOG_ROWS-1:0]                    row,
	output logic                                          ctrl_rdy,
	// frame buffer read
	output logic [`HUB75_LOG_ROWS-1:0]                    ram_row,
	output logic [`HUB75_LOG_COLS-1:0]                    ram_col,
	output logic                                          ram_rden,
	input  hub75_pkg::pixel_t [`HUB75_N_BANKS-1:0]        ram_data,
	// to phy
	output logic [`HUB75_N_BANKS*`HUB75_N_CHANS-1:0]      phy_data,
	output logic                                          phy_clk
);

	localparam int CW = `HUB75_LOG_COLS + 2;                  // holds 2*cols
	localparam logic [CW-1:0] LAST = CW'(2 * `HUB75_N_COLS);

	logic                                        busy;
	logic [CW-1:0]                               cnt;      // even = read, odd = data back
	logic [`HUB75_N_PLANES-1:0]                  plane_q;
	logic [`HUB75_LOG_ROWS-1:0]                  row_q;
	logic [`HUB75_N_BANKS*`HUB75_N_CHANS-1:0]    bits;

	// plane bit of r, g, b for every bank
	always_comb begin
		for (int b = 0; b < `HUB75_N_BANKS; b++) begin
			bits[b*`HUB75_N_CHANS + 0] = |(ram_data[b].r & plane_q);
			bits[b*`HUB75_N_CHANS + 1] = |(ram_data[b].g & plane_q);
			bits[b*`HUB75_N_CHANS + 2] = |(ram_data[b].b & plane_q);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy     <= 1'b0;
			cnt      <= '0;
			plane_q  <= '0;
			row_q    <= '0;
			phy_data <= '0;
			phy_clk  <= 1'b0;
		end else begin
			if (ctrl_go) begin
				busy    <= 1'b1;
				cnt     <= '0;
				plane_q <= ctrl_plane;
				row_q   <= row;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == LAST)
					busy <= 1'b0;               // 2*cols + 1 cycles
			end
			if (busy && cnt[0])
				phy_data <= bits;               // new column, clk low
			phy_clk <= busy && !cnt[0] && (cnt != '0);   // rising half
		end
	end

	assign ctrl_rdy = ~busy;
	assign ram_row  = row_q;
	assign ram_col  = cnt[`HUB75_LOG_COLS:1];
	assign ram_rden = busy && !cnt[0] && (cnt != LAST);

endmodule

// File: logic/hub75_blanking.sv
// **********************************************************
// hub75 blanking timer
// lights the panel for bit_len << plane cycles
// **********************************************************

`timescale 1ns/1ps

`include "hub75_macros.svh"

module hub75_blanking (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          ctrl_go,
	input  logic [`HUB75_N_PLANES-1:0]    ctrl_plane,   // one-hot weight
	input  logic [7:0]                    bit_len,
	output logic                          ctrl_rdy,
	output logic                          phy_blank
);

	localparam int CW = 8 + `HUB75_N_PLANES;    // longest plane fits

	logic            busy;
	logic [CW-1:0]   cnt;
	logic [CW-1:0]   len;

	// one-hot plane as multiplier == shift by plane index
	assign len = CW'(bit_len) * CW'(ctrl_plane);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (ctrl_go) begin
			busy <= 1'b1;
			cnt  <= len;
		end else if (busy) begin
			if (cnt <= CW'(1))
				busy <= 1'b0;                   // time's up, blank again
			else
				cnt <= cnt - 1'b1;
		end
	end

	assign ctrl_rdy  = ~busy;
	assign phy_blank = ~busy;                   // low = lit

	a_go_when_rdy: assert property (
		@(posedge clk) disable iff (rst)
		ctrl_go |-> ctrl_rdy
	) else $error("blanking restarted mid display");

endmodule

// File: logic/hub75_phy.sv
// **********************************************************
// hub75 pin stage
// one register on every panel pin, blanked out of reset
// **********************************************************

`timescale 1ns/1ps

`include "hub75_macros.svh"

module hub75_phy (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic [`HUB75_LOG_ROWS-1:0]                  addr,
	input  logic [`HUB75_N_BANKS*`HUB75_N_CHANS-1:0]    data,
	input  logic                                        sclk,    // shift clock
	input  logic                                        le,
	input  logic                                        blank,
	output hub75_pkg::hub75_pins_t                      pins
);

	// same depth on all pins keeps clk/data/le alignment
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pins.addr  <= '0;
			pins.data  <= '0;
			pins.clk   <= 1'b0;
			pins.le    <= 1'b0;
			pins.blank <= 1'b1;                 // dark until first plane
		end else begin
			pins.addr  <= addr;
			pins.data  <= data;
			pins.clk   <= sclk;
			pins.le    <= le;
			pins.blank <= blank;
		end
	end

endmodule

// File: logic/hub75_top.sv
// **********************************************************
// hub75 matrix driver
// frame buffer, scan, bcm, shifter, blanking and pin stage,
// plus the frame swap handshake with the host
// **********************************************************

`timescale 1ns/1ps

`include "hub75_macros.svh"

module hub75_top (
	input  logic                      clk,
	input  logic                      rst,
	input  hub75_pkg::fb_wr_t         fb_wr,        // host pixel write
	input  logic                      frame_swap,   // pulse, show back buffer
	output logic                      frame_rdy,    // low while swap pending
	input  logic                      ctrl_run,
	input  hub75_pkg::hub75_cfg_t     cfg,
	output hub75_pkg::hub75_pins_t    pins
);

	logic swap_pending;
	logic fb_swap;

	logic scan_go, scan_rdy;
	logic bcm_go, bcm_rdy;
	logic [`HUB75_LOG_ROWS-1:0] bcm_row;

	logic shift_go, shift_rdy;
	logic [`HUB75_N_PLANES-1:0] shift_plane;
	logic blank_go, blank_rdy;
	logic [`HUB75_N_PLANES-1:0] blank_plane;

	logic [`HUB75_LOG_ROWS-1:0] fb_rd_row;
	logic [`HUB75_LOG_COLS-1:0] fb_rd_col;
	logic fb_rd_en;
	hub75_pkg::pixel_t [`HUB75_N_BANKS-1:0] fb_rd_data;

	logic [`HUB75_LOG_ROWS-1:0] phy_addr;
	logic [`HUB75_N_BANKS*`HUB75_N_CHANS-1:0] phy_data;
	logic phy_clk, phy_le, phy_blank;

	// swap waits for the scan to sit between frames
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			swap_pending <= 1'b0;
		else
			swap_pending <= (swap_pending & ~scan_rdy) | frame_swap;
	end

	assign frame_rdy = ~swap_pending;
	assign fb_swap   = swap_pending & scan_rdy;               // one cycle, flag clears
	assign scan_go   = scan_rdy & ~swap_pending & ctrl_run;   // hold off until swapped

	hub75_framebuffer u_fb (
		.clk(clk), .rst(rst),
		.wr(fb_wr),                  // host
		.swap(fb_swap),              // local
		.rd_row(fb_rd_row),          // shifter
		.rd_col(fb_rd_col),
		.rd_en(fb_rd_en),
		.rd_data(fb_rd_data)
	);

	hub75_scan u_scan (
		.clk(clk), .rst(rst),
		.ctrl_go(scan_go), .ctrl_rdy(scan_rdy),
		.bcm_go(bcm_go), .bcm_row(bcm_row), .bcm_rdy(bcm_rdy)
	);

	hub75_bcm u_bcm (
		.clk(clk), .rst(rst),
		.ctrl_go(bcm_go), .ctrl_row(bcm_row), .ctrl_rdy(bcm_rdy),
		.cfg(cfg),
		.shift_go(shift_go), .shift_plane(shift_plane), .shift_rdy(shift_rdy),
		.blank_go(blank_go), .blank_plane(blank_plane), .blank_rdy(blank_rdy),
		.phy_addr(phy_addr), .phy_le(phy_le)
	);

	hub75_shift u_shift (
		.clk(clk), .rst(rst),
		.ctrl_go(shift_go), .ctrl_plane(shift_plane),
		.row(bcm_row),               // stable for the whole row
		.ctrl_rdy(shift_rdy),
		.ram_row(fb_rd_row), .ram_col(fb_rd_col), .ram_rden(fb_rd_en),
		.ram_data(fb_rd_data),
		.phy_data(phy_data), .phy_clk(phy_clk)
	);

	hub75_blanking u_blank (
		.clk(clk), .rst(rst),
		.ctrl_go(blank_go), .ctrl_plane(blank_plane),
		.bit_len(cfg.bit_len),
		.ctrl_rdy(blank_rdy), .phy_blank(phy_blank)
	);

	hub75_phy u_phy (
		.clk(clk), .rst(rst),
		.addr(phy_addr), .data(phy_data), .sclk(phy_clk),
		.le(phy_le), .blank(phy_blank),
		.pins(pins)
	);

endmodule

// File: tb/hub75_tb.sv
// **********************************************************
// hub75 driver testbench
// directed tests against a panel model that captures the
// shifted columns, each latch and every blank-low time
// **********************************************************

`timescale 1ns/1ps

`include "hub75_macros.svh"

module hub75_tb;

	localparam int DW = `HUB75_N_BANKS * `HUB75_N_CHANS;        // pin data width
	localparam int FRAME_LATCHES = `HUB75_N_ROWS * `HUB75_N_PLANES;
	localparam hub75_pkg::hub75_cfg_t CFG_A = {8'd2, 8'd2, 8'd2, 8'd8};    // short planes
	localparam hub75_pkg::hub75_cfg_t CFG_B = {8'd3, 8'd2, 8'd4, 8'd20};   // longer planes

	typedef struct packed {
		logic [`HUB75_LOG_ROWS-1:0]        addr;
		logic [`HUB75_N_COLS-1:0][DW-1:0]  cols;                 // col k at index k
	} latch_t;

	logic                    clk;
	logic                    rst;
	hub75_pkg::fb_wr_t       fb_wr;
	logic                    frame_swap;
	logic                    frame_rdy;
	logic                    ctrl_run;
	hub75_pkg::hub75_cfg_t   cfg;
	hub75_pkg::hub75_pins_t  pins;

	hub75_pkg::pixel_t ref_img [2][`HUB75_N_BANKS][`HUB75_N_ROWS][`HUB75_N_COLS];
	int           front_ref;                                     // model of the shown buffer
	logic [31:0]  lcg_state;
	latch_t       latch_q[$];
	int           blank_q[$];                                    // blank-low lengths, cycles
	int           errors, errors_at_start, tests_run, tests_failed;

	// panel model state
	logic [`HUB75_N_COLS-1:0][DW-1:0] shreg;
	logic  prev_clk, prev_le, prev_blank;
	int    cycle, blank_start;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;                                  // 40 ns period
	end

	hub75_top u_dut (
		.clk(clk), .rst(rst),
		.fb_wr(fb_wr), .frame_swap(frame_swap), .frame_rdy(frame_rdy),
		.ctrl_run(ctrl_run), .cfg(cfg), .pins(pins)
	);

	// pins sampled on the clock edge, before the phy updates them
	always @(posedge clk) begin
		if (rst) begin
			prev_clk   = 1'b0;
			prev_le    = 1'b0;
			prev_blank = 1'b1;
			cycle      = 0;
		end else begin
			cycle++;
			if (pins.clk && !prev_clk)
				shreg = {pins.data, shreg[`HUB75_N_COLS-1:1]};   // first column ends at 0
			if (pins.le && !prev_le)
				latch_q.push_back({pins.addr, shreg});
			if (!pins.blank && prev_blank)
				blank_start = cycle;                             // panel lit
			if (pins.blank && !prev_blank)
				blank_q.push_back(cycle - blank_start);
			prev_clk   = pins.clk;
			prev_le    = pins.le;
			prev_blank = pins.blank;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// upper bound of one frame in cycles
	function automatic int frame_cycles(input hub75_pkg::hub75_cfg_t c);
		int plane_ovh;
		plane_ovh = 40 + c.pre_latch_len + c.latch_len + c.post_latch_len;
		return `HUB75_N_ROWS * (`HUB75_N_PLANES * plane_ovh +
			(1 << `HUB75_N_PLANES) * c.bit_len + 8);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;                                                      // drive point
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input logic [`HUB75_LOG_ROWS-1:0] got,
			input logic [`HUB75_LOG_ROWS-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(input string name, input logic [DW-1:0] got,
			input logic [DW-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_len(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pixel(input string name, input hub75_pkg::pixel_t got,
			input hub75_pkg::pixel_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input int num, input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED with %0d errors", num, name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// every pixel of the hidden buffer, back to back
	task automatic fill_back();
		hub75_pkg::pixel_t pix;
		for (int b = 0; b < `HUB75_N_BANKS; b++)
			for (int r = 0; r < `HUB75_N_ROWS; r++)
				for (int c = 0; c < `HUB75_N_COLS; c++) begin
					lcg_state = lcg_next(lcg_state);
					pix = lcg_state[27:16];                      // upper bits, better spread
					fb_wr.en   = 1'b1;
					fb_wr.bank = b[`HUB75_LOG_BANKS-1:0];
					fb_wr.row  = r[`HUB75_LOG_ROWS-1:0];
					fb_wr.col  = c[`HUB75_LOG_COLS-1:0];
					fb_wr.data = pix;
					ref_img[1 - front_ref][b][r][c] = pix;
					next_cycle();
				end
		fb_wr.en = 1'b0;
	endtask

	task automatic request_swap();
		frame_swap = 1'b1;
		next_cycle();
		frame_swap = 1'b0;                                       // single-cycle pulse
	endtask

	task automatic wait_frame_rdy();
		int n = 0;
		while (!frame_rdy && n < 2 * frame_cycles(cfg)) begin
			next_cycle();
			n++;
		end
		if (!frame_rdy) begin
			$display("frame_rdy did not return after a frame swap");
			errors++;
		end else begin
			front_ref = 1 - front_ref;                           // swap accepted
		end
	endtask

	task automatic wait_latches(input int count);
		int n = 0;
		while (latch_q.size() < count && n < (count / FRAME_LATCHES + 2) * frame_cycles(cfg)) begin
			next_cycle();
			n++;
		end
		if (latch_q.size() < count) begin
			$display("timed out waiting for %0d latches, saw %0d", count, latch_q.size());
			errors++;
		end
	endtask

	task automatic wait_blanks(input int count);
		int n = 0;
		while (blank_q.size() < count && n < (count / FRAME_LATCHES + 2) * frame_cycles(cfg)) begin
			next_cycle();
			n++;
		end
		if (blank_q.size() < count) begin
			$display("timed out waiting for %0d blank periods, saw %0d", count, blank_q.size());
			errors++;
		end
	endtask

	task automatic run_frames(input int frames);
		latch_q.delete();
		blank_q.delete();
		ctrl_run = 1'b1;
		wait_latches(frames * FRAME_LATCHES);
		ctrl_run = 1'b0;                                         // current frame still finishes
		wait_blanks(frames * FRAME_LATCHES);
		repeat (4) next_cycle();
	endtask

	// rebuild each pixel from the four plane latches of its row
	task automatic check_frame(input int base, input int buf_idx);
		hub75_pkg::pixel_t got;
		latch_t lat;
		if (latch_q.size() < base + FRAME_LATCHES) begin
			$display("frame incomplete, only %0d latches captured", latch_q.size());
			errors++;
			return;
		end
		for (int g = 0; g < `HUB75_N_ROWS; g++) begin
			for (int b = 0; b < `HUB75_N_BANKS; b++)
				for (int k = 0; k < `HUB75_N_COLS; k++) begin
					for (int p = 0; p < `HUB75_N_PLANES; p++) begin
						lat = latch_q[base + g * `HUB75_N_PLANES + p];
						got.r[p] = lat.cols[k][b * `HUB75_N_CHANS + 0];
						got.g[p] = lat.cols[k][b * `HUB75_N_CHANS + 1];
						got.b[p] = lat.cols[k][b * `HUB75_N_CHANS + 2];
					end
					check_pixel($sformatf("pixel bank%0d row%0d col%0d", b, g, k),
						got, ref_img[buf_idx][b][g][k]);
				end
		end
	endtask

	task automatic check_order(input int base);
		if (latch_q.size() < base + FRAME_LATCHES) begin
			$display("only %0d latches captured for the order check", latch_q.size());
			errors++;
			return;
		end
		for (int i = 0; i < FRAME_LATCHES; i++)
			check_addr($sformatf("latch_addr[%0d]", i), latch_q[base + i].addr,
				i / `HUB75_N_PLANES);                            // planes inner, rows outer
	endtask

	task automatic check_blanks(input int base, input logic [7:0] bit_len);
		if (blank_q.size() < base + FRAME_LATCHES) begin
			$display("only %0d blank periods captured", blank_q.size());
			errors++;
			return;
		end
		for (int i = 0; i < FRAME_LATCHES; i++)
			check_len($sformatf("blank_len[%0d]", i), blank_q[base + i],
				16'(bit_len) << (i % `HUB75_N_PLANES));
	endtask

	initial begin
		int n;
		int old_front;
		rst        = 1'b1;
		fb_wr      = '0;
		frame_swap = 1'b0;
		ctrl_run   = 1'b0;
		cfg        = CFG_A;
		lcg_state  = 32'h5536;
		front_ref  = 0;
		errors = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		next_cycle();

		check_bit("pins.blank", pins.blank, 1'b1);
		check_bit("pins.le", pins.le, 1'b0);
		check_bit("pins.clk", pins.clk, 1'b0);
		check_addr("pins.addr", pins.addr, '0);
		check_data("pins.data", pins.data, '0);
		check_bit("frame_rdy", frame_rdy, 1'b1);
		finish_test(1, "reset state");

		fill_back();                                             // buffer 1
		request_swap();
		wait_frame_rdy();                                        // scan idle, immediate
		run_frames(1);
		check_frame(0, front_ref);
		finish_test(2, "swap and data");

		check_order(0);
		finish_test(3, "row and plane order");

		check_blanks(0, CFG_A.bit_len);
		cfg = CFG_B;
		run_frames(1);
		check_blanks(0, CFG_B.bit_len);
		check_frame(0, front_ref);
		cfg = CFG_A;
		finish_test(4, "bcm weighting");

		fill_back();                                             // hidden until next swap
		old_front = front_ref;
		latch_q.delete();
		blank_q.delete();
		ctrl_run = 1'b1;
		wait_latches(1);
		request_swap();                                          // mid frame
		n = 0;
		while (latch_q.size() < FRAME_LATCHES && n < 2 * frame_cycles(cfg)) begin
			check_bit("frame_rdy", frame_rdy, 1'b0);
			next_cycle();
			n++;
		end
		wait_frame_rdy();
		if (blank_q.size() < FRAME_LATCHES) begin
			$display("frame_rdy returned before the frame had ended");
			errors++;
		end
		wait_latches(2 * FRAME_LATCHES);
		ctrl_run = 1'b0;
		wait_blanks(2 * FRAME_LATCHES);
		check_frame(0, old_front);                               // old image still shown
		check_frame(FRAME_LATCHES, front_ref);
		finish_test(5, "double buffering");

		latch_q.delete();
		blank_q.delete();
		ctrl_run = 1'b1;
		wait_latches(5);
		ctrl_run = 1'b0;                                         // stop mid frame
		wait_blanks(FRAME_LATCHES);
		repeat (200) next_cycle();                               // room for a stray row
		if (latch_q.size() != FRAME_LATCHES) begin
			$display("%0d latches after stop, expected %0d", latch_q.size(), FRAME_LATCHES);
			errors++;
		end
		check_bit("pins.blank", pins.blank, 1'b1);
		finish_test(6, "stop");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// four slow frames per test plus slack
	initial begin
		int limit;
		limit = 6 * 4 * frame_cycles(CFG_B) + 2000;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: hub75_lite.f
+incdir+include
logic/hub75_pkg.sv
logic/hub75_framebuffer.sv
logic/hub75_scan.sv
logic/hub75_bcm.sv
logic/hub75_shift.sv
logic/hub75_blanking.sv
logic/hub75_phy.sv
logic/hub75_top.sv
tb/hub75_tb.sv
